// File: src.f
common/road_pkg.sv
verilog/hazard_check.sv
verilog/tick_timer.sv
verilog/player_mover.sv
verilog/car_lanes.sv
verilog/game_ctrl.sv
verilog/road_crosser_top.sv
verif/road_crosser_chk.sv
verif/road_crosser_tb.sv

// File: Bender.yml
package:
  name: road_crosser

sources:
  - common/road_pkg.sv
  - verilog/hazard_check.sv
  - verilog/tick_timer.sv
  - verilog/player_mover.sv
  - verilog/car_lanes.sv
  - verilog/game_ctrl.sv
  - verilog/road_crosser_top.sv
  - target: test
    files:
      - verif/road_crosser_chk.sv
      - verif/road_crosser_tb.sv

// File: verif/road_crosser_tb.sv
/* Cycle model testbench for the game core. Inputs change on the rising edge,
   outputs are compared on the falling edge against the model. */
`timescale 1ns/1ps

module road_crosser_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int GAME_CYCLES  = 4000;
    localparam int MAX_GAMES    = 20;
    localparam int TEST_CYCLES  = 15 * GAME_CYCLES;
    localparam time WATCHDOG_NS = (RESET_CYCLES + MAX_GAMES * GAME_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h6ae7a770;

    logic                  clock = 1'b0;
    logic                  rst_n;
    logic [3:0]            sw;
    logic                  go;
    road_pkg::keys_t       keys;
    road_pkg::pos_t        player;
    road_pkg::cars_t       cars;
    road_pkg::lives_t      lives;
    road_pkg::score_t      score;
    road_pkg::ncars_t      num_cars;
    road_pkg::game_state_t state;

    // Model of the game core
    road_pkg::game_state_t m_state;
    road_pkg::lives_t      m_lives;
    road_pkg::score_t      m_score;
    road_pkg::ncars_t      m_ncars;
    road_pkg::pos_t        m_player;
    road_pkg::cars_t       m_cars;
    int                    m_count;
    logic                  hunt;
    // 1 runs to the left edge, 2 to the right edge, other values go straight
    int                    edge_side;
    int                    cycle;
    int                    hits;
    int                    goals;
    int                    games;

    road_crosser_top i_road_crosser_top (
        .clock    (clock),
        .rst_n    (rst_n),
        .sw       (sw),
        .go       (go),
        .keys     (keys),
        .player   (player),
        .cars     (cars),
        .lives    (lives),
        .score    (score),
        .num_cars (num_cars),
        .state    (state)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic compare_pos(input string name, input road_pkg::pos_t exp_v,
                               input road_pkg::pos_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("ERROR %s: expected (%0d,%0d) actual (%0d,%0d)",
                               name, exp_v.x, exp_v.y, act_v.x, act_v.y));
    endtask

    task automatic compare_cars(input string name, input road_pkg::cars_t exp_v,
                                input road_pkg::cars_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("ERROR %s: expected %h actual %h", name, exp_v, act_v));
    endtask

    task automatic compare_lives(input string name, input road_pkg::lives_t exp_v,
                                 input road_pkg::lives_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("ERROR %s: expected %0d actual %0d", name, exp_v, act_v));
    endtask

    task automatic compare_score(input string name, input road_pkg::score_t exp_v,
                                 input road_pkg::score_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("ERROR %s: expected %0d actual %0d", name, exp_v, act_v));
    endtask

    task automatic compare_ncars(input string name, input road_pkg::ncars_t exp_v,
                                 input road_pkg::ncars_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("ERROR %s: expected %0d actual %0d", name, exp_v, act_v));
    endtask

    task automatic compare_state(input string name, input road_pkg::game_state_t exp_v,
                                 input road_pkg::game_state_t act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("ERROR %s: expected %0d (%s) actual %0d", name, exp_v,
                               exp_v.name(), act_v));
    endtask

    // Car i at column i times the spacing, in its own lane
    function automatic road_pkg::cars_t spaced_cars();
        road_pkg::cars_t c;
        for (int i = 0; i < road_pkg::MAX_CARS; i++)
        begin
            c[i].x = road_pkg::xcoord_t'(i * road_pkg::CAR_SPACING);
            c[i].y = road_pkg::LANE_Y[i];
        end
        return c;
    endfunction

    task automatic model_reset();
        m_state    = road_pkg::S_LIVES;
        m_lives    = 4'd1;
        m_score    = 8'd0;
        m_ncars    = 3'd1;
        m_count    = 0;
        m_player.x = road_pkg::START_X;
        m_player.y = road_pkg::START_Y;
        m_cars     = spaced_cars();
        hunt       = 1'b0;
        edge_side  = 0;
    endtask

    // One clock edge of the game rules, using the inputs sampled at that edge
    task automatic model_step();
        road_pkg::game_state_t n_state;
        road_pkg::lives_t      n_lives;
        road_pkg::score_t      n_score;
        road_pkg::ncars_t      n_ncars;
        road_pkg::pos_t        n_player;
        road_pkg::cars_t       n_cars;
        logic                  run;
        logic                  tick;
        logic                  hit;
        logic                  goal;
        run  = (m_state == road_pkg::S_PLAY) || (m_state == road_pkg::S_RESPAWN);
        tick = run && (m_count == road_pkg::TICK_PERIOD - 1);
        hit  = 1'b0;
        for (int i = 0; i < road_pkg::MAX_CARS; i++)
        begin
            if (i < m_ncars && m_cars[i].x == m_player.x && m_cars[i].y == m_player.y)
                hit = 1'b1;
        end
        goal     = (m_player.y == road_pkg::GOAL_Y);
        n_state  = m_state;
        n_lives  = m_lives;
        n_score  = m_score;
        n_ncars  = m_ncars;
        n_player = m_player;
        n_cars   = m_cars;
        case (m_state)
            road_pkg::S_LIVES, road_pkg::S_OVER:
                if (go)
                begin
                    n_lives = (sw == 4'd0) ? 4'd1 : sw;
                    n_state = road_pkg::S_LIVES_WAIT;
                end
            road_pkg::S_LIVES_WAIT:
                if (!go)
                    n_state = road_pkg::S_CARS;
            road_pkg::S_CARS:
                if (go)
                begin
                    n_ncars = 3'(sw[1:0]) + 3'd1;
                    n_state = road_pkg::S_CARS_WAIT;
                end
            road_pkg::S_CARS_WAIT:
                if (!go)
                    n_state = road_pkg::S_START;
            road_pkg::S_START:
            begin
                n_score = 8'd0;
                n_state = road_pkg::S_PLAY;
            end
            road_pkg::S_PLAY:
                if (hit)
                begin
                    hits++;
                    n_lives = m_lives - 4'd1;
                    n_state = (m_lives == 4'd1) ? road_pkg::S_OVER : road_pkg::S_RESPAWN;
                    if (m_lives == 4'd1)
                        games++;
                end
                else if (goal)
                begin
                    goals++;
                    n_score = m_score + 8'd1;
                    n_state = road_pkg::S_RESPAWN;
                end
            default:
                n_state = road_pkg::S_PLAY;
        endcase
        if (m_state == road_pkg::S_START || m_state == road_pkg::S_RESPAWN)
        begin
            n_player.x = road_pkg::START_X;
            n_player.y = road_pkg::START_Y;
        end
        else if (tick)
        begin
            if (keys.up)
                n_player.y = (m_player.y == 0) ? m_player.y : m_player.y - 7'd1;
            else if (keys.down)
                n_player.y = (m_player.y == road_pkg::MAX_Y) ? m_player.y : m_player.y + 7'd1;
            else if (keys.left)
                n_player.x = (m_player.x == 0) ? m_player.x : m_player.x - 8'd1;
            else if (keys.right)
                n_player.x = (m_player.x == road_pkg::MAX_X) ? m_player.x : m_player.x + 8'd1;
        end
        if (m_state == road_pkg::S_START)
            n_cars = spaced_cars();
        else if (tick)
        begin
            for (int i = 0; i < road_pkg::MAX_CARS; i++)
                n_cars[i].x = (m_cars[i].x == road_pkg::MAX_X) ? 8'd0 : m_cars[i].x + 8'd1;
        end
        m_count  = (!run || tick) ? 0 : m_count + 1;
        // New crossing goes for the goal, waits for a car or runs to a side edge
        if (n_state == road_pkg::S_RESPAWN || n_state == road_pkg::S_START)
        begin
            hunt      = ($urandom % 2 == 0);
            edge_side = hunt ? 0 : int'($urandom % 4);
        end
        m_state  = n_state;
        m_lives  = n_lives;
        m_score  = n_score;
        m_ncars  = n_ncars;
        m_player = n_player;
        m_cars   = n_cars;
    endtask

    task automatic drive_inputs();
        logic [3:0]      sw_val;
        logic            go_val;
        logic            on_lane;
        logic            at_edge;
        road_pkg::keys_t k;
        // Small values most of the time so that games end
        sw_val = ($urandom % 4 == 0) ? 4'($urandom % 16) : 4'($urandom % 4);
        case (m_state)
            road_pkg::S_LIVES, road_pkg::S_CARS, road_pkg::S_OVER:
                go_val = ($urandom % 4 == 0);
            road_pkg::S_LIVES_WAIT, road_pkg::S_CARS_WAIT:
                go_val = ($urandom % 2 == 0);
            default:
                go_val = ($urandom % 32 == 0);
        endcase
        // Inactive lanes too, where sharing a cell must cost nothing
        on_lane = 1'b0;
        for (int i = 0; i < road_pkg::MAX_CARS; i++)
        begin
            if (road_pkg::LANE_Y[i] == m_player.y)
                on_lane = 1'b1;
        end
        if (edge_side == 1 || edge_side == 2)
        begin
            // Push against the edge, climbing only once it is reached
            at_edge = (edge_side == 1) ? (m_player.x == 8'd0) :
                                         (m_player.x == road_pkg::MAX_X);
            k.up    = at_edge && ($urandom % 2 == 0);
            k.down  = 1'b0;
            k.left  = (edge_side == 1);
            k.right = (edge_side == 2);
        end
        else if (hunt && on_lane)
        begin
            k.up    = ($urandom % 16 == 0);
            k.down  = 1'b0;
            k.left  = 1'b1;
            k.right = 1'b0;
        end
        else
        begin
            k.up    = ($urandom % 4 != 0);
            k.down  = $urandom % 2;
            k.left  = $urandom % 2;
            k.right = $urandom % 2;
        end
        sw   <= sw_val;
        go   <= go_val;
        keys <= k;
    endtask

    task automatic check_outputs(input string tag);
        compare_state({tag, " state"}, m_state, state);
        compare_lives({tag, " lives"}, m_lives, lives);
        compare_score({tag, " score"}, m_score, score);
        compare_ncars({tag, " num_cars"}, m_ncars, num_cars);
        compare_pos({tag, " player"}, m_player, player);
        compare_cars({tag, " cars"}, m_cars, cars);
    endtask

    initial
    begin
        rst_n = 1'b0;
        sw    = 4'd0;
        go    = 1'b0;
        keys  = '0;
        hits  = 0;
        goals = 0;
        games = 0;
        void'($urandom(SEED));
        model_reset();
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_outputs("reset");
        for (cycle = 0; cycle < TEST_CYCLES; cycle++)
        begin
            @(posedge clock);
            model_step();
            drive_inputs();
            @(negedge clock);
            check_outputs($sformatf("cycle %0d", cycle));
        end
        if (hits > 0 && goals > 0 && games > 0)
        begin
            $display("STATUS: PASS");
            $finish;
        end
        else
            fail_run($sformatf("Run ended without a hit, a goal and a game over (%0d/%0d/%0d)",
                               hits, goals, games));
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        fail_run("Watchdog expired before the test finished");
    end

endmodule

// File: verif/road_crosser_chk.sv
/* Protocol checks on the game core, attached to the top level by bind. */
`timescale 1ns/1ps

module road_crosser_chk (
    input logic                  clock,
    input logic                  rst_n,
    input logic                  tick,
    input logic                  start,
    input road_pkg::game_state_t state,
    input road_pkg::lives_t      lives,
    input road_pkg::pos_t        player
);

    tick_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        tick |=> !tick)
        else $error("tick high for more than one cycle");

    // Lives only grow when a new game is set up
    lives_rise_setup: assert property (@(posedge clock) disable iff (!rst_n)
        (lives > $past(lives)) |->
            ($past(state) == road_pkg::S_LIVES || $past(state) == road_pkg::S_OVER))
        else $error("lives rose outside setup");

    player_on_grid: assert property (@(posedge clock) disable iff (!rst_n)
        player.x <= road_pkg::MAX_X && player.y <= road_pkg::MAX_Y)
        else $error("player left the grid");

    start_to_play: assert property (@(posedge clock) disable iff (!rst_n)
        start |=> state == road_pkg::S_PLAY)
        else $error("start not followed by play");

endmodule

bind road_crosser_top road_crosser_chk i_road_crosser_chk (
    .clock  (clock),
    .rst_n  (rst_n),
    .tick   (tick),
    .start  (start),
    .state  (state),
    .lives  (lives),
    .player (player)
);

// File: verilog/road_crosser_top.sv
/* Game core only, no video path. go is a level; the positions, lives
   and score outputs are meant for a separate renderer. */
`timescale 1ns/1ps

module road_crosser_top (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic [3:0]               sw,
    input  logic                     go,
    input  road_pkg::keys_t          keys,
    output road_pkg::pos_t           player,
    output road_pkg::cars_t          cars,
    output road_pkg::lives_t         lives,
    output road_pkg::score_t         score,
    output road_pkg::ncars_t         num_cars,
    output road_pkg::game_state_t    state
);

    logic start;
    logic respawn;
    logic tick_en;
    logic tick;
    logic hit;
    logic goal;

    game_ctrl i_game_ctrl (
        .clock    (clock),
        .rst_n    (rst_n),
        .sw       (sw),
        .go       (go),
        .hit      (hit),
        .goal     (goal),
        .state    (state),
        .lives    (lives),
        .score    (score),
        .num_cars (num_cars),
        .start    (start),
        .respawn  (respawn),
        .tick_en  (tick_en)
    );

    tick_timer i_tick_timer (
        .clock   (clock),
        .rst_n   (rst_n),
        .tick_en (tick_en),
        .tick    (tick)
    );

    player_mover i_player_mover (
        .clock   (clock),
        .rst_n   (rst_n),
        .start   (start),
        .respawn (respawn),
        .tick    (tick),
        .keys    (keys),
        .player  (player)
    );

    car_lanes i_car_lanes (
        .clock (clock),
        .rst_n (rst_n),
        .start (start),
        .tick  (tick),
        .cars  (cars)
    );

    hazard_check i_hazard_check (
        .player   (player),
        .cars     (cars),
        .num_cars (num_cars),
        .hit      (hit),
        .goal     (goal)
    );

endmodule

// File: verilog/game_ctrl.sv
/* Setup and play FSM. Each setup value is taken on go high and the FSM
   waits for go low before the next step; hit wins over goal. */
`timescale 1ns/1ps

module game_ctrl (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic [3:0]               sw,
    input  logic                     go,
    input  logic                     hit,
    input  logic                     goal,
    output road_pkg::game_state_t    state,
    output road_pkg::lives_t         lives,
    output road_pkg::score_t         score,
    output road_pkg::ncars_t         num_cars,
    output logic                     start,
    output logic                     respawn,
    output logic                     tick_en
);

    road_pkg::lives_t sw_lives;
    road_pkg::ncars_t sw_cars;

    // Zero lives on the switches still gives one life
    assign sw_lives = (sw == 4'd0) ? road_pkg::lives_t'(1) : sw;
    // Two switch bits select 1 to 4 cars
    assign sw_cars  = road_pkg::ncars_t'(sw[1:0]) + road_pkg::ncars_t'(1);

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= road_pkg::S_LIVES;
            lives    <= road_pkg::lives_t'(1);
            score    <= '0;
            num_cars <= road_pkg::ncars_t'(1);
        end
        else
        begin
            case (state)
                road_pkg::S_LIVES, road_pkg::S_OVER:
                begin
                    if (go)
                    begin
                        lives <= sw_lives;
                        state <= road_pkg::S_LIVES_WAIT;
                    end
                end
                road_pkg::S_LIVES_WAIT:
                begin
                    if (!go)
                        state <= road_pkg::S_CARS;
                end
                road_pkg::S_CARS:
                begin
                    if (go)
                    begin
                        num_cars <= sw_cars;
                        state    <= road_pkg::S_CARS_WAIT;
                    end
                end
                road_pkg::S_CARS_WAIT:
                begin
                    if (!go)
                        state <= road_pkg::S_START;
                end
                road_pkg::S_START:
                begin
                    score <= '0;
                    state <= road_pkg::S_PLAY;
                end
                road_pkg::S_PLAY:
                begin
                    if (hit)
                    begin
                        lives <= lives - road_pkg::lives_t'(1);
                        // Last life gone
                        if (lives == road_pkg::lives_t'(1))
                            state <= road_pkg::S_OVER;
                        else
                            state <= road_pkg::S_RESPAWN;
                    end
                    else if (goal)
                    begin
                        score <= score + road_pkg::score_t'(1);
                        state <= road_pkg::S_RESPAWN;
                    end
                end
                road_pkg::S_RESPAWN:
                begin
                    state <= road_pkg::S_PLAY;
                end
                default:
                begin
                    state <= road_pkg::S_LIVES;
                end
            endcase
        end
    end

    // Control pulses decoded from the registered state
    assign start   = (state == road_pkg::S_START);
    assign respawn = (state == road_pkg::S_RESPAWN);
    assign tick_en = (state == road_pkg::S_PLAY) || (state == road_pkg::S_RESPAWN);

endmodule

// File: verilog/car_lanes.sv
/* All lanes move together, inactive cars included; the hazard check
   ignores cars above the active count. */
`timescale 1ns/1ps

module car_lanes (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              start,
    input  logic              tick,
    output road_pkg::cars_t   cars
);

    // Spaced start layout, car i in lane i
    function automatic road_pkg::cars_t initial_cars();
        road_pkg::cars_t layout;
        for (int i = 0; i < road_pkg::MAX_CARS; i++)
        begin
            layout[i].x = road_pkg::xcoord_t'(i * road_pkg::CAR_SPACING);
            layout[i].y = road_pkg::LANE_Y[i];
        end
        return layout;
    endfunction

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            cars <= initial_cars();
        else if (start)
            cars <= initial_cars();
        else if (tick)
        begin
            for (int i = 0; i < road_pkg::MAX_CARS; i++)
            begin
                // Wrap from the right edge back to column 0
                if (cars[i].x == road_pkg::MAX_X)
                    cars[i].x <= '0;
                else
                    cars[i].x <= cars[i].x + 1'b1;
            end
        end
    end

endmodule

// File: verilog/player_mover.sv
/* Player cell register. One key per tick in order up, down, left, right;
   a blocked key is dropped, not passed on to the next one. */
`timescale 1ns/1ps

module player_mover (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              start,
    input  logic              respawn,
    input  logic              tick,
    input  road_pkg::keys_t   keys,
    output road_pkg::pos_t    player
);

    road_pkg::pos_t next_pos;

    // Key priority and edge blocking
    always_comb
    begin
        next_pos = player;
        if (keys.up)
        begin
            if (player.y != '0)
                next_pos.y = player.y - 1'b1;
        end
        else if (keys.down)
        begin
            if (player.y != road_pkg::MAX_Y)
                next_pos.y = player.y + 1'b1;
        end
        else if (keys.left)
        begin
            if (player.x != '0)
                next_pos.x = player.x - 1'b1;
        end
        else if (keys.right)
        begin
            if (player.x != road_pkg::MAX_X)
                next_pos.x = player.x + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            player.x <= road_pkg::START_X;
            player.y <= road_pkg::START_Y;
        end
        else if (start || respawn)
        begin
            player.x <= road_pkg::START_X;
            player.y <= road_pkg::START_Y;
        end
        else if (tick)
        begin
            player <= next_pos;
        end
    end

endmodule

// File: verilog/tick_timer.sv
/* Movement rate divider. Counter is held at zero while disabled, so the
   first tick comes TICK_PERIOD cycles after enable rises. */
`timescale 1ns/1ps

module tick_timer (
    input  logic clock,
    input  logic rst_n,
    input  logic tick_en,
    output logic tick
);

    logic [road_pkg::TICK_W-1:0] count;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            count <= '0;
        else if (!tick_en || count == road_pkg::TICK_LAST)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    // High during the last count of each period
    assign tick = tick_en && (count == road_pkg::TICK_LAST);

endmodule

// File: verilog/hazard_check.sv
/* Purely combinational; hit and goal follow the registered positions
   in the same cycle and are acted on only in play. */
`timescale 1ns/1ps

module hazard_check (
    input  road_pkg::pos_t    player,
    input  road_pkg::cars_t   cars,
    input  road_pkg::ncars_t  num_cars,
    output logic              hit,
    output logic              goal
);

    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < road_pkg::MAX_CARS; i++)
        begin
            // Only the first num_cars lanes are live
            if (road_pkg::ncars_t'(i) < num_cars && cars[i] == player)
                hit = 1'b1;
        end
    end

    assign goal = (player.y == road_pkg::GOAL_Y);

endmodule

// File: common/road_pkg.sv
/* Grid, lane and timing constants with the shared types of the game core.
   Origin is the top left cell; x grows right, y grows down. */
package road_pkg;

    localparam int X_W = 8;
    localparam int Y_W = 7;

    typedef logic [X_W-1:0] xcoord_t;
    typedef logic [Y_W-1:0] ycoord_t;

    // Grid limits
    localparam xcoord_t MAX_X  = 8'd159;
    localparam ycoord_t MAX_Y  = 7'd119;
    localparam ycoord_t GOAL_Y = 7'd0;

    // Respawn cell, bottom row of the safe zone (rows 100 to 119)
    localparam xcoord_t START_X = 8'd80;
    localparam ycoord_t START_Y = MAX_Y;

    localparam int MAX_CARS    = 4;
    localparam int CAR_SPACING = 40;

    // Lane row per car, entry 0 is car 0
    localparam logic [MAX_CARS-1:0][Y_W-1:0] LANE_Y = {7'd80, 7'd60, 7'd40, 7'd20};

    // Movement rate
    localparam int TICK_PERIOD = 8;
    localparam int TICK_W      = $clog2(TICK_PERIOD);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICK_PERIOD - 1);

    typedef struct packed {
        xcoord_t x;
        ycoord_t y;
    } pos_t;

    // Active high buttons
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } keys_t;

    typedef pos_t [MAX_CARS-1:0] cars_t;

    typedef logic [3:0] lives_t;
    typedef logic [7:0] score_t;
    typedef logic [2:0] ncars_t;

    typedef enum logic [2:0] {
        S_LIVES,
        S_LIVES_WAIT,
        S_CARS,
        S_CARS_WAIT,
        S_START,
        S_PLAY,
        S_RESPAWN,
        S_OVER
    } game_state_t;

endpackage
